/* sources.f */
+incdir+common
common/snd_pkg.sv
src/snd_bus_decoder.sv
voice/snd_voice_regs.sv
voice/snd_voice.sv
voice/snd_mixer.sv
src/snd_board.sv
verification/snd_board_checker.sv
verification/snd_board_tb.sv

/* Makefile */
# Verilator build and run for the sound board testbench
VERILATOR ?= verilator
TOP       ?= snd_board_tb
RTL_TOP   ?= snd_board
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/snd_board_tb.sv */
// directed tests only; the ROM model answers one access at a time after 0 to 5 cycles
`include "snd_config.svh"

module snd_board_tb;
    import snd_pkg::*;

    localparam int STROBES  = 300;                      // strobes per tone test
    localparam int AMP_UNIT = 1 << `SND_VOL_SHIFT;      // amplitude per volume step
    // tone tests plus bus traffic, doubled
    localparam int LIMIT    = 2 * (8 + 4 * STROBES * `SND_SAMPLE_DIV + 100 * 20);

    logic      clk;
    logic      rst;
    logic      req;
    logic      we;
    logic      ack;
    logic      rom_cs;
    logic      rom_ok;
    logic      sample;
    snd_addr_t addr;
    snd_data_t wdata;
    snd_data_t rdata;
    snd_data_t latch0;
    snd_data_t latch1;
    snd_data_t rom_data;
    rom_addr_t rom_addr;
    rom_addr_t rom_addr_first;                          // rom_addr when the access opens
    rom_addr_t rom_addr_served;                         // rom_addr when rom_ok is given
    audio_t    left;
    audio_t    right;
    integer    seed = 32'ha5d1c67d;

    snd_board DUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .req      ( req      ),
        .addr     ( addr     ),
        .wdata    ( wdata    ),
        .we       ( we       ),
        .ack      ( ack      ),
        .rdata    ( rdata    ),
        .latch0   ( latch0   ),
        .latch1   ( latch1   ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .left     ( left     ),
        .right    ( right    ),
        .sample   ( sample   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ROM contents, low byte xor high byte
    function automatic snd_data_t rom_byte(input rom_addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    // fixed window keeps A14:0, banked window is 1, bank, A13:0
    function automatic rom_addr_t expect_rom_addr(input snd_addr_t a, input logic b);
        return a[15] ? {1'b1, b, a[13:0]} : {1'b0, a[14:0]};
    endfunction

    function automatic snd_data_t ram_fill(input snd_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // behavioral ROM, random wait per access
    initial begin
        int unsigned d;
        rom_ok          = 1'b0;
        rom_data        = '0;
        rom_addr_first  = '0;
        rom_addr_served = '0;
        forever begin
            @(negedge clk);
            if (rom_cs) begin
                rom_addr_first = rom_addr;
                d = $unsigned($random(seed)) % 6;
                repeat (d) @(negedge clk);
                rom_addr_served = rom_addr;
                rom_data = rom_byte(rom_addr);
                rom_ok   = 1'b1;
                @(negedge clk);
                rom_ok   = 1'b0;
            end
        end
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_member(input string name, input int actual,
                                input int a, input int b, input int c, input int d);
        assert (actual == a || actual == b || actual == c || actual == d) else begin
            $display("CHECK FAILED %s: expected one of %0d %0d %0d %0d, actual %0d",
                     name, a, b, c, d, actual);
            stop_on_error();
        end
    endtask

    // address must be right at cs and still the same at rom_ok
    task automatic check_rom_addr(input string name, input rom_addr_t expected);
        check_value({name, " addr at cs"}, int'(expected), int'(rom_addr_first));
        check_value({name, " addr at ok"}, int'(expected), int'(rom_addr_served));
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level) begin
            @(negedge clk);
            n++;
            if (n > 40) begin
                $display("bus handshake stuck, ack never went to %0b", level);
                stop_on_error();
            end
        end
    endtask

    task automatic bus_write(input snd_addr_t a, input snd_data_t d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        we    = 1'b1;
        req   = 1'b1;
        wait_ack(1'b1);
        req = 1'b0;                     // addr and we held until ack drops
        wait_ack(1'b0);
        we = 1'b0;
    endtask

    task automatic bus_read(input snd_addr_t a, output snd_data_t d);
        @(negedge clk);
        addr = a;
        we   = 1'b0;
        req  = 1'b1;
        wait_ack(1'b1);
        d   = rdata;
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic next_sample();
        do begin
            @(negedge clk);
        end while (sample !== 1'b1);
    endtask

    task automatic set_voice(input voice_idx_t v, input period_t p, input volume_t vol,
                             input pan_t pn);
        snd_addr_t base;
        base = 16'he000 | {10'b0, v, 4'b0};
        bus_write(base | 16'd2, vol);               // volume and pan before period
        bus_write(base | 16'd3, {6'b0, pn});
        bus_write(base | 16'd1, {4'b0, p[11:8]});
        bus_write(base, p[7:0]);
    endtask

    task automatic test_reset_state();
        check_value("reset ack", 0, int'(ack));
        check_value("reset rom_cs", 0, int'(rom_cs));
        for (int i = 0; i < 20; i++) begin
            next_sample();
            check_value("reset left", 0, int'(left));
            check_value("reset right", 0, int'(right));
        end
    endtask

    task automatic test_rom();
        snd_addr_t a;
        snd_data_t d;
        for (int i = 0; i < 6; i++) begin
            a = 16'h1234 + 16'(i) * 16'h1111;      // fixed window only
            bus_read(a, d);
            check_rom_addr("rom fixed", expect_rom_addr(a, 1'b0));
            check_value("rom fixed", int'(rom_byte(expect_rom_addr(a, 1'b0))), int'(d));
        end
        bus_read(16'h9abc, d);
        check_rom_addr("rom bank 0", expect_rom_addr(16'h9abc, 1'b0));
        check_value("rom bank 0", int'(rom_byte(expect_rom_addr(16'h9abc, 1'b0))), int'(d));
        bus_write(16'hf004, 8'h01);                 // bank register
        for (int i = 0; i < 4; i++) begin
            a = 16'h9abc + 16'(i) * 16'h0707;
            bus_read(a, d);
            check_rom_addr("rom bank 1", expect_rom_addr(a, 1'b1));
            check_value("rom bank 1", int'(rom_byte(expect_rom_addr(a, 1'b1))), int'(d));
        end
        bus_write(16'hf004, 8'h00);
    endtask

    task automatic test_ram();
        snd_addr_t a;
        snd_data_t d;
        snd_addr_t holes [4] = '{16'hc000, 16'hd800, 16'he012, 16'hf000};
        for (int i = 0; i < 8; i++) begin
            a = 16'hd000 + 16'(i) * 16'h0123;
            bus_write(a, ram_fill(a));
        end
        for (int i = 0; i < 8; i++) begin
            a = 16'hd000 + 16'(i) * 16'h0123;
            bus_read(a, d);
            check_value("ram readback", int'(ram_fill(a)), int'(d));
        end
        foreach (holes[i]) begin
            bus_read(holes[i], d);                  // unmapped, voice area, unused control
            check_value("unmapped read", 255, int'(d));
        end
    endtask

    task automatic test_latches();
        snd_data_t d;
        @(negedge clk);
        latch0 = 8'h3c;
        latch1 = 8'hc5;
        bus_read(16'hf008, d);
        check_value("latch 0", 8'h3c, int'(d));
        bus_read(16'hf00a, d);
        check_value("latch 1", 8'hc5, int'(d));
    endtask

    task automatic test_single_voice();
        int pos;
        int neg;
        int hi;
        pos = 0;
        neg = 0;
        hi  = 100 * AMP_UNIT;
        set_voice(2'd0, 12'd10, 8'd100, 2'd1);
        next_sample();                              // may hold a word from before the writes
        for (int i = 0; i < STROBES; i++) begin
            next_sample();
            check_member("single voice left", int'(left), hi, -hi, hi, -hi);
            check_value("single voice right", 0, int'(right));
            if (left > 0)
                pos++;
            else
                neg++;
        end
        assert (pos > 0 && neg > 0) else begin
            $display("single voice output never changed sign");
            stop_on_error();
        end
    endtask

    task automatic test_mix();
        int a1;
        int a2;
        a1 = 50 * AMP_UNIT;
        a2 = 30 * AMP_UNIT;
        set_voice(2'd0, 12'd0, 8'd0, 2'd0);         // voice 0 off
        set_voice(2'd1, 12'd7, 8'd50, 2'd3);
        set_voice(2'd2, 12'd13, 8'd30, 2'd3);
        next_sample();
        for (int i = 0; i < STROBES; i++) begin
            next_sample();
            check_value("mix left equals right", int'(left), int'(right));
            check_member("mix left", int'(left), a1 + a2, a1 - a2, a2 - a1, -a1 - a2);
        end
    endtask

    task automatic test_silence();
        snd_addr_t base;
        for (int v = 0; v < `SND_VOICES; v++) begin
            base = 16'he000 | 16'(v << 4);
            bus_write(base | 16'd1, 8'h00);
            bus_write(base, 8'h00);
        end
        next_sample();
        for (int i = 0; i < 20; i++) begin
            next_sample();
            check_value("silence left", 0, int'(left));
            check_value("silence right", 0, int'(right));
        end
    endtask

    // watchdog
    initial begin
        #(LIMIT * 100);
        $display("timeout, tests did not finish within %0d clock cycles", LIMIT);
        stop_on_error();
    end

    initial begin
        rst    = 1'b1;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        latch0 = '0;
        latch1 = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_rom();
        test_ram();
        test_latches();
        test_single_voice();
        test_mix();
        test_silence();
        $display("Test passed");
        $finish;
    end

endmodule

/* verification/snd_board_checker.sv */
// sampled on posedge clk and idle in reset; assumes the master holds req until ack rises
module snd_board_checker (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic rom_cs,
    input logic sample
);

    // ack only answers a pending req
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    ack_held: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
        else $error("ack dropped while req still high");

    // ROM select lives inside one bus access
    rom_cs_in_req: assert property (@(posedge clk) disable iff (rst) rom_cs |-> req)
        else $error("rom_cs high without req");

    sample_pulse: assert property (@(posedge clk) disable iff (rst) sample |=> !sample)
        else $error("sample longer than one cycle");

endmodule

bind snd_board snd_board_checker u_chk (
    .clk    ( clk    ),
    .rst    ( rst    ),
    .req    ( req    ),
    .ack    ( ack    ),
    .rom_cs ( rom_cs ),
    .sample ( sample )
);

/* src/snd_board.sv */
// everything on clk with no enables; the bus master stands in for the sound CPU
`include "snd_config.svh"

module snd_board (
    input  logic               clk,
    input  logic               rst,
    // four-phase bus
    input  logic               req,
    input  snd_pkg::snd_addr_t addr,
    input  snd_pkg::snd_data_t wdata,
    input  logic               we,
    output logic               ack,
    output snd_pkg::snd_data_t rdata,
    // latches from main CPU
    input  snd_pkg::snd_data_t latch0,
    input  snd_pkg::snd_data_t latch1,
    // ROM
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::snd_data_t rom_data,
    input  logic               rom_ok,
    // audio
    output snd_pkg::audio_t    left,
    output snd_pkg::audio_t    right,
    output logic               sample
);
    import snd_pkg::*;

    logic       reg_we;
    voice_idx_t reg_voice;
    reg_sel_t   reg_sel;
    snd_data_t  reg_data;
    period_t    period [`SND_VOICES];
    volume_t    volume [`SND_VOICES];
    pan_t       pan    [`SND_VOICES];
    audio_t     amp    [`SND_VOICES];

    snd_bus_decoder u_dec (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req       ( req       ),
        .addr      ( addr      ),
        .wdata     ( wdata     ),
        .we        ( we        ),
        .ack       ( ack       ),
        .rdata     ( rdata     ),
        .latch0    ( latch0    ),
        .latch1    ( latch1    ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .reg_we    ( reg_we    ),
        .reg_voice ( reg_voice ),
        .reg_sel   ( reg_sel   ),
        .reg_data  ( reg_data  )
    );

    snd_voice_regs u_regs (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .reg_we    ( reg_we    ),
        .reg_voice ( reg_voice ),
        .reg_sel   ( reg_sel   ),
        .reg_data  ( reg_data  ),
        .period    ( period    ),
        .volume    ( volume    ),
        .pan       ( pan       )
    );

    // one tone generator per voice
    for (genvar i = 0; i < `SND_VOICES; i++) begin : g_voice
        snd_voice u_voice (
            .clk    ( clk       ),
            .rst    ( rst       ),
            .period ( period[i] ),
            .volume ( volume[i] ),
            .amp    ( amp[i]    )
        );
    end

    snd_mixer u_mix (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .amp    ( amp    ),
        .pan    ( pan    ),
        .left   ( left   ),
        .right  ( right  ),
        .sample ( sample )
    );

endmodule

/* voice/snd_mixer.sv */
// plain sum without clipping; output words are held between sample strobes
`include "snd_config.svh"

module snd_mixer (
    input  logic            clk,
    input  logic            rst,
    input  snd_pkg::audio_t amp [`SND_VOICES],
    input  snd_pkg::pan_t   pan [`SND_VOICES],
    output snd_pkg::audio_t left,
    output snd_pkg::audio_t right,
    output logic            sample
);
    import snd_pkg::*;

    localparam int CNT_W = $clog2(`SND_SAMPLE_DIV);

    logic [CNT_W-1:0] cnt;      // sample rate divider
    logic             strobe;   // last cycle of the period
    audio_t           sum_l;
    audio_t           sum_r;

    assign strobe = cnt == CNT_W'(`SND_SAMPLE_DIV - 1);

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < `SND_VOICES; v++) begin
            if (pan[v][0])
                sum_l = sum_l + amp[v];
            if (pan[v][1])
                sum_r = sum_r + amp[v];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            sample <= 1'b0;
            left   <= '0;
            right  <= '0;
        end else begin
            cnt    <= strobe ? '0 : cnt + 1'b1;
            sample <= strobe;           // one clk wide
            if (strobe) begin
                // new words appear together with sample
                left  <= sum_l;
                right <= sum_r;
            end
        end
    end

endmodule

/* voice/snd_voice.sv */
// square wave only; a period change lands at the next tick, period 0 mutes and resets phase
`include "snd_config.svh"

module snd_voice (
    input  logic             clk,
    input  logic             rst,
    input  snd_pkg::period_t period,
    input  snd_pkg::volume_t volume,
    output snd_pkg::audio_t  amp
);
    import snd_pkg::*;

    localparam int PRE_W = $clog2(`SND_TONE_DIV);

    logic [PRE_W-1:0] pre;   // tick prescaler
    logic             tick;
    period_t          cnt;   // ticks into current half wave
    logic             pol;   // 1 is positive half
    audio_t           mag;

    assign tick = pre == PRE_W'(`SND_TONE_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre <= '0;
            cnt <= '0;
            pol <= 1'b0;
        end else begin
            pre <= tick ? '0 : pre + 1'b1;
            if (period == '0) begin
                cnt <= '0;
                pol <= 1'b0;
            end else if (tick) begin
                // >= catches a period cut below the running count
                if (cnt >= period - 1'b1) begin
                    cnt <= '0;
                    pol <= ~pol;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    assign mag = audio_t'(volume) << `SND_VOL_SHIFT;
    assign amp = (period == '0) ? '0 : (pol ? mag : -mag);

endmodule

/* voice/snd_voice_regs.sv */
// write-only register file; a write shows on the voice outputs one cycle after reg_we
`include "snd_config.svh"

module snd_voice_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                reg_we,
    input  snd_pkg::voice_idx_t reg_voice,
    input  snd_pkg::reg_sel_t   reg_sel,
    input  snd_pkg::snd_data_t  reg_data,
    output snd_pkg::period_t    period [`SND_VOICES],
    output snd_pkg::volume_t    volume [`SND_VOICES],
    output snd_pkg::pan_t       pan    [`SND_VOICES]
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // all voices silent and unpanned
            for (int v = 0; v < `SND_VOICES; v++) begin
                period[v] <= '0;
                volume[v] <= '0;
                pan[v]    <= '0;
            end
        end else if (reg_we) begin
            case (reg_sel)
                2'd0: period[reg_voice][7:0]  <= reg_data;       // low byte
                2'd1: period[reg_voice][11:8] <= reg_data[3:0];  // upper nibble only
                2'd2: volume[reg_voice]       <= reg_data;
                default: begin
                    // pan bits 1:0
                    pan[reg_voice] <= reg_data[1:0];
                end
            endcase
        end
    end

endmodule

/* src/snd_bus_decoder.sv */
// one access at a time; rom_ok is only honoured while rom_cs is high and ROM writes are dropped
`include "snd_config.svh"

module snd_bus_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  snd_pkg::snd_addr_t  addr,
    input  snd_pkg::snd_data_t  wdata,
    input  logic                we,
    output logic                ack,
    output snd_pkg::snd_data_t  rdata,
    input  snd_pkg::snd_data_t  latch0,
    input  snd_pkg::snd_data_t  latch1,
    output snd_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    input  snd_pkg::snd_data_t  rom_data,
    input  logic                rom_ok,
    output logic                reg_we,
    output snd_pkg::voice_idx_t reg_voice,
    output snd_pkg::reg_sel_t   reg_sel,
    output snd_pkg::snd_data_t  reg_data
);
    import snd_pkg::*;

    dec_state_t state;
    bank_t      bank;
    snd_data_t  ram [2**`SND_RAM_AW];   // work RAM at 0xD000
    logic       start;                  // access accepted on this edge
    logic       fix_sel;
    logic       bnk_sel;
    logic       ram_sel;
    logic       voice_sel;
    logic       bank_sel;
    logic       latch0_sel;
    logic       latch1_sel;
    logic       rom_rd;
    rom_addr_t  rom_addr_nx;
    snd_data_t  rd_mux;

    // only from idle with ack already low
    assign start = (state == DEC_IDLE) && req && !ack;

    always_comb begin
        fix_sel    = ~addr[15];                         // 0000-7fff
        bnk_sel    = addr[15:14] == 2'b10;              // 8000-bfff
        ram_sel    = (addr[15:12] == 4'hd) && (addr[11:`SND_RAM_AW] == '0);
        voice_sel  = addr[15:12] == 4'he;
        // control page, A3:1 picks the register
        bank_sel   = (addr[15:12] == 4'hf) && (addr[3:1] == 3'd2);
        latch0_sel = (addr[15:12] == 4'hf) && (addr[3:1] == 3'd4);
        latch1_sel = (addr[15:12] == 4'hf) && (addr[3:1] == 3'd5);
        rom_rd     = start && !we && (fix_sel || bnk_sel);
        rom_addr_nx = fix_sel ? {1'b0, addr[14:0]} : {1'b1, bank, addr[13:0]};
        // read mux for non-ROM reads
        if (ram_sel) begin
            rd_mux = ram[addr[`SND_RAM_AW-1:0]];
        end else if (latch0_sel) begin
            rd_mux = latch0;
        end else if (latch1_sel) begin
            rd_mux = latch1;
        end else begin
            rd_mux = 8'hff;                             // unmapped and voice area
        end
    end

    // voice writes go straight out as a one-cycle pulse
    assign reg_we    = start && we && voice_sel;
    assign reg_voice = addr[5:4];
    assign reg_sel   = addr[1:0];
    assign reg_data  = wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= DEC_IDLE;
            ack    <= 1'b0;
            rom_cs <= 1'b0;
            bank   <= '0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (rom_rd) begin
                        rom_cs <= 1'b1;                 // address latched below
                        state  <= DEC_ROM_WAIT;
                    end else if (start) begin
                        if (we && bank_sel)
                            bank <= wdata[0];
                        state <= DEC_ACK;               // ack on next edge
                    end
                end
                DEC_ROM_WAIT: begin
                    if (rom_ok && rom_cs) begin
                        rom_cs <= 1'b0;
                        ack    <= 1'b1;
                        state  <= DEC_ACK;
                    end
                end
                DEC_ACK: begin
                    ack <= req;                         // held while master keeps req
                    if (!req)
                        state <= DEC_IDLE;
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // RAM and data path
    always_ff @(posedge clk) begin
        if (start && we && ram_sel)
            ram[addr[`SND_RAM_AW-1:0]] <= wdata;
        if (start) begin
            rdata    <= rd_mux;
            rom_addr <= rom_addr_nx;                    // steady through the wait
        end
        if (state == DEC_ROM_WAIT && rom_ok)
            rdata <= rom_data;
    end

endmodule

/* common/snd_pkg.sv */
// shared types only; widths of the voice fields follow the register map of the bus decoder
package snd_pkg;

    // bus side
    typedef logic [15:0] snd_addr_t;   // sound CPU address
    typedef logic [7:0]  snd_data_t;   // bus data and latches
    typedef logic [15:0] rom_addr_t;   // external ROM address
    typedef logic        bank_t;       // banked ROM window select

    // voice register port
    typedef logic [1:0]  voice_idx_t;  // addr bits 5:4
    typedef logic [1:0]  reg_sel_t;    // addr bits 1:0
    // field codes
    // 0 period low byte
    // 1 period high nibble
    // 2 volume
    // 3 pan

    // voice fields
    typedef logic [11:0] period_t;     // half period in ticks, 0 is silent
    typedef logic [7:0]  volume_t;
    typedef logic [1:0]  pan_t;        // bit 0 left, bit 1 right

    // samples
    typedef logic signed [15:0] audio_t;

    // handshake and ROM wait
    typedef enum logic [1:0] {
        DEC_IDLE,      // waiting for req
        DEC_ROM_WAIT,  // rom_cs up, waiting for rom_ok
        DEC_ACK        // ack phase, waits for req low
    } dec_state_t;

endpackage

/* common/snd_config.svh */
// compile-time sizes for the sound board; four voices at volume 255 must still fit 16 bits signed
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// number of tone voices
// generate loop and register file both follow this
`define SND_VOICES 4

// clk cycles per voice counter tick
`define SND_TONE_DIV 16

// clk cycles between mixer sample strobes
`define SND_SAMPLE_DIV 64

// work RAM address width
// 11 bits gives 2 KB at 0xD000
`define SND_RAM_AW 11

// volume to amplitude scaling
// 255 << 5 = 8160 per voice
// so 4 voices peak at 32640
`define SND_VOL_SHIFT 5

`endif
